// File: source/softmax_cfg_pkg.sv
`default_nettype none

package softmax_cfg_pkg;

  // signed Q4.4 activations
  localparam int in_width  = 8;
  localparam int in_frac   = 4;

  // unsigned Q4.8 exponential that saturates at all ones
  localparam int exp_width = 12;
  localparam int exp_frac  = 8;

  // unsigned Q2.4 probability
  localparam int out_width = 6;
  localparam int out_frac  = 4;

  localparam int beat_elems    = 2;
  localparam int vec_len       = 8;
  localparam int beats_per_vec = vec_len / beat_elems;  // 4

  localparam int sum_width      = exp_width + $clog2(beat_elems);     // one beat
  localparam int acc_width      = sum_width + $clog2(beats_per_vec);  // whole vector
  localparam int dividend_width = exp_width + out_frac;

  localparam int exp_fifo_depth = 2 * beats_per_vec;  // two vectors in flight
  localparam int sum_fifo_depth = 2;

endpackage

`default_nettype wire

// File: source/softmax_types_pkg.sv
`default_nettype none

package softmax_types_pkg;

  typedef logic signed [softmax_cfg_pkg::in_width-1:0] in_elem_t;
  typedef logic [softmax_cfg_pkg::exp_width-1:0] exp_elem_t;
  typedef logic [softmax_cfg_pkg::out_width-1:0] out_elem_t;

  // intermediate arithmetic widths
  typedef logic [softmax_cfg_pkg::sum_width-1:0] beat_sum_t;
  typedef logic [softmax_cfg_pkg::acc_width-1:0] acc_t;
  typedef logic [softmax_cfg_pkg::dividend_width-1:0] dividend_t;

  typedef struct packed {
    in_elem_t [softmax_cfg_pkg::beat_elems-1:0] elem;
  } in_beat_t;   // 16 bits

  typedef struct packed {
    exp_elem_t [softmax_cfg_pkg::beat_elems-1:0] elem;
  } exp_beat_t;  // 24 bits

  typedef struct packed {
    out_elem_t [softmax_cfg_pkg::beat_elems-1:0] elem;
  } out_beat_t;  // 12 bits

  typedef struct packed {
    acc_t value;
  } vec_sum_t;   // 15 bits

endpackage

`default_nettype wire

// File: source/exp_lut.sv
`timescale 1ns/1ps
`default_nettype none

module exp_lut (
  input  wire signed [softmax_cfg_pkg::in_width-1:0] x,
  output logic       [softmax_cfg_pkg::exp_width-1:0] y
);

  // e^x for every Q4.4 code floored to Q4.8
  // clamped to [1, max] so no vector sum can be zero
  function automatic logic [2**softmax_cfg_pkg::in_width-1:0][softmax_cfg_pkg::exp_width-1:0]
      calc_exp_table();
    logic [2**softmax_cfg_pkg::in_width-1:0][softmax_cfg_pkg::exp_width-1:0] tbl;
    int   code;
    real  xv;
    real  scaled;
    real  exp_max;
    exp_max = real'(2**softmax_cfg_pkg::exp_width - 1);
    for (int i = 0; i < 2**softmax_cfg_pkg::in_width; i++) begin
      code = (i >= 2**(softmax_cfg_pkg::in_width-1)) ? i - 2**softmax_cfg_pkg::in_width : i;
      xv = real'(code) / real'(2**softmax_cfg_pkg::in_frac);
      scaled = $exp(xv) * real'(2**softmax_cfg_pkg::exp_frac);
      if (scaled >= exp_max) begin
        tbl[i] = '1;  // x >= ~2.77
      end else if (scaled < 1.0) begin
        tbl[i] = softmax_types_pkg::exp_elem_t'(1);
      end else begin
        tbl[i] = softmax_types_pkg::exp_elem_t'($rtoi(scaled));  // truncates = floor here
      end
    end
    return tbl;
  endfunction

  localparam logic [2**softmax_cfg_pkg::in_width-1:0][softmax_cfg_pkg::exp_width-1:0]
      exp_table = calc_exp_table();

  // raw code is the index so negatives wrap to the top half
  assign y = exp_table[$unsigned(x)];

endmodule

`default_nettype wire

// File: source/beat_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module beat_fifo #(
  parameter type payload_t = logic,
  parameter int  depth     = 2
) (
  input  wire           clk,
  input  wire           rst_n,
  input  wire payload_t in_data,
  input  wire           in_valid,
  output logic          in_ready,
  output payload_t      out_data,
  output logic          out_valid,
  input  wire           out_ready
);

  payload_t                     mem [depth];
  logic [$clog2(depth)-1:0]     wr_ptr;
  logic [$clog2(depth)-1:0]     rd_ptr;
  logic [$clog2(depth+1)-1:0]   count;
  logic                         push;
  logic                         pop;

  assign out_valid = (count != '0);
  assign in_ready  = (count != depth) || out_ready;  // full slot frees on a pop
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;
  assign out_data  = mem[rd_ptr];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= (wr_ptr == depth - 1) ? '0 : wr_ptr + 1'b1;
      if (pop)  rd_ptr <= (rd_ptr == depth - 1) ? '0 : rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

  // payload storage
  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= in_data;
  end

  // occupancy never grows past the buffer size
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    count <= depth);

endmodule

`default_nettype wire

// File: source/vector_sum_acc.sv
`timescale 1ns/1ps
`default_nettype none

module vector_sum_acc (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire softmax_types_pkg::exp_beat_t in_beat,
  input  wire                          in_valid,
  output logic                         in_ready,
  output softmax_types_pkg::vec_sum_t  sum,
  output logic                         sum_valid,
  input  wire                          sum_ready
);

  softmax_types_pkg::beat_sum_t                      beat_sum;
  softmax_types_pkg::acc_t                           acc;
  logic [$clog2(softmax_cfg_pkg::beats_per_vec)-1:0] beat_cnt;
  logic                                              in_fire;
  logic                                              last_beat;

  // held sum blocks new beats until it drains
  assign in_ready  = !sum_valid || sum_ready;
  assign in_fire   = in_valid && in_ready;
  assign last_beat = (beat_cnt == softmax_cfg_pkg::beats_per_vec - 1);

  always_comb begin
    beat_sum = '0;
    for (int i = 0; i < softmax_cfg_pkg::beat_elems; i++) begin
      beat_sum = beat_sum + softmax_types_pkg::beat_sum_t'(in_beat.elem[i]);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc       <= '0;
      beat_cnt  <= '0;
      sum_valid <= 1'b0;
    end else begin
      if (sum_valid && sum_ready) sum_valid <= 1'b0;
      if (in_fire) begin
        if (last_beat) begin
          acc       <= '0;
          beat_cnt  <= '0;
          sum_valid <= 1'b1;  // overrides the drain above
        end else begin
          acc      <= acc + softmax_types_pkg::acc_t'(beat_sum);
          beat_cnt <= beat_cnt + 1'b1;
        end
      end
    end
  end

  // vector total
  always_ff @(posedge clk) begin
    if (in_fire && last_beat) sum.value <= acc + softmax_types_pkg::acc_t'(beat_sum);
  end

  // a held sum keeps its value until the queue takes it
  a_sum_held: assert property (@(posedge clk) disable iff (!rst_n)
    (sum_valid && !sum_ready) |=> (sum_valid && $stable(sum)));

endmodule

`default_nettype wire

// File: source/norm_div.sv
`timescale 1ns/1ps
`default_nettype none

module norm_div (
  input  wire                               clk,
  input  wire                               rst_n,
  input  wire softmax_types_pkg::exp_beat_t exp_beat,
  input  wire                               exp_valid,
  output logic                              exp_ready,
  input  wire softmax_types_pkg::vec_sum_t  sum,
  input  wire                               sum_valid,
  output logic                              sum_ready,
  output softmax_types_pkg::out_beat_t      out_beat,
  output logic                              out_valid,
  input  wire                               out_ready
);

  softmax_types_pkg::dividend_t dividend [softmax_cfg_pkg::beat_elems];
  softmax_types_pkg::dividend_t quotient [softmax_cfg_pkg::beat_elems];
  softmax_types_pkg::out_beat_t next_out;
  logic [$clog2(softmax_cfg_pkg::beats_per_vec)-1:0] beat_cnt;
  logic                         fire;

  // stage free if empty or draining this cycle
  assign fire      = exp_valid && sum_valid && (!out_valid || out_ready);
  assign exp_ready = fire;
  assign sum_ready = fire && (beat_cnt == softmax_cfg_pkg::beats_per_vec - 1);  // last beat

  always_comb begin
    for (int i = 0; i < softmax_cfg_pkg::beat_elems; i++) begin
      dividend[i] = softmax_types_pkg::dividend_t'(exp_beat.elem[i]) << softmax_cfg_pkg::out_frac;
      quotient[i] = dividend[i] / softmax_types_pkg::dividend_t'(sum.value);  // truncates
      // clamp anything above the Q2.4 range
      if (|quotient[i][softmax_cfg_pkg::dividend_width-1:softmax_cfg_pkg::out_width]) begin
        next_out.elem[i] = '1;
      end else begin
        next_out.elem[i] = quotient[i][softmax_cfg_pkg::out_width-1:0];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      beat_cnt  <= '0;
    end else begin
      if (fire) begin
        out_valid <= 1'b1;
        beat_cnt  <= beat_cnt + 1'b1;  // wraps at four
      end else if (out_ready) begin
        out_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fire) out_beat <= next_out;
  end

  // relies on the lut never producing a zero exponential
  a_sum_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
    fire |-> (sum.value != '0));

endmodule

`default_nettype wire

// File: source/fixed_softmax.sv
`timescale 1ns/1ps
`default_nettype none

module fixed_softmax (
  input  wire                              clk,
  input  wire                              rst_n,
  input  wire softmax_types_pkg::in_beat_t in_beat,
  input  wire                              in_valid,
  output logic                             in_ready,
  output softmax_types_pkg::out_beat_t     out_beat,
  output logic                             out_valid,
  input  wire                              out_ready
);

  wire softmax_types_pkg::exp_beat_t in_exp;  // lut outputs
  softmax_types_pkg::exp_beat_t      buf_exp;
  softmax_types_pkg::vec_sum_t       acc_sum;
  softmax_types_pkg::vec_sum_t       head_sum;

  logic buf_in_valid;
  logic buf_in_ready;
  logic acc_in_valid;
  logic acc_in_ready;
  logic acc_sum_valid;
  logic acc_sum_ready;
  logic buf_out_valid;
  logic buf_out_ready;
  logic head_sum_valid;
  logic head_sum_ready;

  // both sides take the beat together or not at all
  assign in_ready     = buf_in_ready && acc_in_ready;
  assign buf_in_valid = in_valid && acc_in_ready;
  assign acc_in_valid = in_valid && buf_in_ready;

  for (genvar i = 0; i < softmax_cfg_pkg::beat_elems; i++) begin : g_exp
    exp_lut u_exp_lut (
      .x (in_beat.elem[i]),
      .y (in_exp.elem[i])
    );
  end

  // exponentials wait here while their vector is summed
  beat_fifo #(
    .payload_t (softmax_types_pkg::exp_beat_t),
    .depth     (softmax_cfg_pkg::exp_fifo_depth)
  ) u_exp_buf (
    .clk, .rst_n,
    .in_data   (in_exp),        .in_valid  (buf_in_valid),  .in_ready  (buf_in_ready),
    .out_data  (buf_exp),       .out_valid (buf_out_valid), .out_ready (buf_out_ready)
  );

  vector_sum_acc u_sum_acc (
    .clk, .rst_n,
    .in_beat   (in_exp),        .in_valid  (acc_in_valid),  .in_ready  (acc_in_ready),
    .sum       (acc_sum),       .sum_valid (acc_sum_valid), .sum_ready (acc_sum_ready)
  );

  beat_fifo #(
    .payload_t (softmax_types_pkg::vec_sum_t),
    .depth     (softmax_cfg_pkg::sum_fifo_depth)
  ) u_sum_queue (
    .clk, .rst_n,
    .in_data   (acc_sum),       .in_valid  (acc_sum_valid),  .in_ready  (acc_sum_ready),
    .out_data  (head_sum),      .out_valid (head_sum_valid), .out_ready (head_sum_ready)
  );

  norm_div u_norm_div (
    .clk, .rst_n,
    .exp_beat  (buf_exp),   .exp_valid (buf_out_valid),  .exp_ready (buf_out_ready),
    .sum       (head_sum),  .sum_valid (head_sum_valid), .sum_ready (head_sum_ready),
    .out_beat,              .out_valid,                  .out_ready
  );

endmodule

`default_nettype wire

// File: tests/softmax_checker.sv
`timescale 1ns/1ps
`default_nettype none

module softmax_checker (
  input wire                               clk,
  input wire                               rst_n,
  input wire                               in_valid,
  input wire                               in_ready,
  input wire softmax_types_pkg::out_beat_t out_beat,
  input wire                               out_valid,
  input wire                               out_ready
);

  typedef struct packed {
    softmax_types_pkg::out_beat_t beat;
    logic [7:0]                   test_id;
    logic                         last;  // closes its test
  } expect_t;

  expect_t exp_q [$];  // pushed by the testbench in send order
  int      pass_count  = 0;
  int      fail_count  = 0;
  int      stray_count = 0;
  int      err_count   = 0;  // mismatches in the running test
  int      beat_idx    = 0;
  logic    seen_input  = 1'b0;
  logic    rst_q       = 1'b0;

  function automatic string test_name(input int id);
    case (id)
      1:       return "reset";
      2:       return "single vector";
      3:       return "streaming";
      4:       return "back-pressure";
      default: return "extremes";
    endcase
  endfunction

  task automatic finish_test(input int id);
    if (err_count == 0) begin
      pass_count++;
      $display("test %0d %s: pass, %0d beats", id, test_name(id), beat_idx);
    end else begin
      fail_count++;
      $display("test %0d %s: FAIL, %0d errors", id, test_name(id), err_count);
    end
    err_count = 0;
    beat_idx  = 0;
  endtask

  always @(posedge clk) begin : watch_dut
    expect_t head;
    rst_q <= rst_n;
    // nothing may come out before the first beat goes in
    if (!seen_input && out_valid) begin
      $display("ERROR at %0d ns: out_valid high before any input", $time);
      err_count++;
    end
    if (rst_n && !rst_q && !in_ready) begin
      $display("ERROR at %0d ns: in_ready low one cycle after reset", $time);
      err_count++;
    end
    if (!seen_input && rst_n && in_valid && in_ready) begin
      seen_input <= 1'b1;
      finish_test(1);
    end
    if (out_valid && out_ready) begin
      if (exp_q.size() == 0) begin
        $display("ERROR at %0d ns: output beat %h with nothing expected", $time, out_beat);
        stray_count++;
      end else begin
        head = exp_q.pop_front();
        if (out_beat !== head.beat) begin
          $display("ERROR at %0d ns: test %0d beat %0d expected %0d,%0d got %0d,%0d",
                   $time, head.test_id, beat_idx, head.beat.elem[0], head.beat.elem[1],
                   out_beat.elem[0], out_beat.elem[1]);
          err_count++;
        end
        beat_idx++;
        if (head.last) finish_test(int'(head.test_id));
      end
    end
  end

endmodule

`default_nettype wire

// File: tests/softmax_tb.sv
`timescale 1ns/1ps
`default_nettype none

module softmax_tb;

  localparam int elems        = softmax_cfg_pkg::vec_len;
  localparam int beats        = softmax_cfg_pkg::beats_per_vec;
  localparam int num_vectors  = 12;
  localparam int sent_vectors = 22;  // 2 single, 8 streaming, 8 stalled, 4 extremes
  localparam int limit_cycles = sent_vectors * beats * 40 + 200;

  logic                         clk;
  logic                         rst_n;
  softmax_types_pkg::in_beat_t  in_beat;
  logic                         in_valid;
  logic                         in_ready;
  softmax_types_pkg::out_beat_t out_beat;
  logic                         out_valid;
  logic                         out_ready;

  logic [7:0] stim_mem [num_vectors * 2 * elems];  // inputs then expected for each vector
  int         seed;
  logic       random_mode;

  fixed_softmax u_fixed_softmax (.*);
  softmax_checker u_checker (.*);

  always #10 clk = ~clk;

  // one clock step with inputs changing 2 ns after the edge
  task automatic next_cycle();
    @(posedge clk);
    #2;
    out_ready = random_mode ? ($random(seed) % 4 != 0) : 1'b1;
  endtask

  task automatic send_beat(input softmax_types_pkg::in_beat_t beat);
    logic accepted;
    accepted = 1'b0;
    in_beat  = beat;
    in_valid = 1'b1;
    while (!accepted) begin
      #1;
      accepted = in_ready;  // settled and held until the edge
      next_cycle();
    end
    in_valid = 1'b0;
  endtask

  task automatic send_vector(input int v, input int test_id, input logic last_vec);
    softmax_types_pkg::in_beat_t  beat;
    softmax_types_pkg::out_beat_t expect_beat;
    for (int b = 0; b < beats; b++) begin
      for (int e = 0; e < softmax_cfg_pkg::beat_elems; e++) begin
        beat.elem[e]        = stim_mem[v * 2 * elems + b * 2 + e];
        expect_beat.elem[e] = stim_mem[v * 2 * elems + elems + b * 2 + e][5:0];
      end
      u_checker.exp_q.push_back({expect_beat, 8'(test_id), last_vec && b == beats - 1});
      while (random_mode && $random(seed) % 3 == 0) next_cycle();  // idle gap
      send_beat(beat);
    end
  endtask

  task automatic wait_drain();
    while (u_checker.exp_q.size() != 0) next_cycle();
  endtask

  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    in_beat     = '0;
    in_valid    = 1'b0;
    out_ready   = 1'b1;
    seed        = 36739;
    random_mode = 1'b0;
    $readmemh("tests/softmax_stimulus.hex", stim_mem);
    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;
    repeat (3) next_cycle();
    send_vector(0, 2, 1'b0);
    wait_drain();
    send_vector(1, 2, 1'b1);
    wait_drain();
    for (int v = 0; v < 8; v++) send_vector(v, 3, v == 7);
    wait_drain();
    random_mode = 1'b1;  // gaps and stalls
    for (int v = 0; v < 8; v++) send_vector(v, 4, v == 7);
    wait_drain();
    random_mode = 1'b0;
    for (int v = 8; v < num_vectors; v++) send_vector(v, 5, v == num_vectors - 1);
    wait_drain();
    repeat (4) next_cycle();  // room for a stray beat
    $display("tests passed: %0d, tests failed: %0d, stray beats: %0d",
             u_checker.pass_count, u_checker.fail_count, u_checker.stray_count);
    if (u_checker.fail_count == 0 && u_checker.stray_count == 0 &&
        u_checker.pass_count == 5) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin
    #(limit_cycles * 20);
    $display("run timed out with %0d output beats still missing", u_checker.exp_q.size());
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/softmax_stimulus.hex
// per vector two lines: eight Q4.4 input bytes (element 0 first),
// then the eight expected Q2.4 outputs in the same element order
00 00 00 00 00 00 00 00
02 02 02 02 02 02 02 02
E0 E8 F0 F8 00 08 10 18
00 00 00 00 01 02 03 06
00 10 00 10 00 10 00 10
01 02 01 02 01 02 01 02
18 10 08 00 F8 F0 E8 E0
06 03 02 01 00 00 00 00
F0 F0 F0 F0 00 00 00 00
01 01 01 01 02 02 02 02
08 F8 08 F8 08 F8 08 F8
02 01 02 01 02 01 02 01
18 00 00 00 00 00 00 00
06 01 01 01 01 01 01 01
E0 E0 E0 E0 E0 E0 E0 10
00 00 00 00 00 00 00 0B
7F 7F 7F 7F 7F 7F 7F 7F
02 02 02 02 02 02 02 02
80 80 80 80 80 80 80 80
02 02 02 02 02 02 02 02
80 80 80 7F 80 80 80 80
00 00 00 0F 00 00 00 00
7F 2D 30 00 C0 80 40 2C
03 03 03 00 00 00 03 03

// File: sim.f
source/softmax_cfg_pkg.sv
source/softmax_types_pkg.sv
source/exp_lut.sv
source/beat_fifo.sv
source/vector_sum_acc.sv
source/norm_div.sv
source/fixed_softmax.sv
tests/softmax_checker.sv
tests/softmax_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module softmax_tb -f sim.f -o softmax_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

sim_output=$(./obj_dir/softmax_sim)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_output" | grep -qF "All tests passed!"; then
  exit 0
fi
exit 1
